/* Bender.yml */
package:
  name: soc_lite

sources:
  - common/soc_bus_pkg.sv
  - common/soc_map_pkg.sv
  - common/obi_bus_if.sv
  - hw/soc_addr_decode.sv
  - mem/sram_bank.sv
  - periph/soc_ctrl_regs.sv
  - periph/gpio_regs.sv
  - hw/soc_rsp_mux.sv
  - hw/soc_lite_top.sv
  - target: test
    files:
      - test/tb_soc_lite.sv

/* common/obi_bus_if.sv */
// ----------------------------
// Request/response bundle between the decoder and one target.
// No grant and no IDs: every request is taken, and the response
// comes exactly one cycle later.
// ----------------------------

`default_nettype none

interface obi_bus_if;

  // Request side
  logic               req;
  logic               we;
  soc_bus_pkg::addr_t addr;
  soc_bus_pkg::data_t wdata;
  soc_bus_pkg::strb_t be;

  // Response side
  logic               rvalid;
  soc_bus_pkg::data_t rdata;
  logic               err;

  modport mgr (output req, we, addr, wdata, be, input rvalid, rdata, err);
  modport sbr (input req, we, addr, wdata, be, output rvalid, rdata, err);
  // Response only, for the return path
  modport mon (input rvalid, rdata, err);

endinterface

`default_nettype wire

/* common/soc_bus_pkg.sv */
// ----------------------------
// Bus widths and data types shared by the whole subsystem.
// Byte addressed, word wide; all targets carry the same payload.
// ----------------------------

`default_nettype none

package soc_bus_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  // One enable per byte lane
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

endpackage

`default_nettype wire

/* common/soc_map_pkg.sv */
// ----------------------------
// Address map of soc_lite and register layout of its peripherals.
// SRAM window is 2 KiB, each peripheral window is 4 KiB.
// Anything outside the three windows goes to the error target.
// ----------------------------

`default_nettype none

package soc_map_pkg;

  typedef enum logic [1:0] {
    TgtSram,
    TgtCtrl,
    TgtGpio,
    TgtError
  } soc_target_e;

  // ------------------------------
  // Windows
  // ------------------------------
  localparam soc_bus_pkg::addr_t SramBaseAddr = 32'h1000_0000;
  localparam int unsigned SramNumWords = 512;
  localparam int unsigned SramIdxWidth = $clog2(SramNumWords);
  localparam int unsigned SramWinBits  = $clog2(SramNumWords * 4);
  localparam soc_bus_pkg::addr_t CtrlBaseAddr = 32'h0300_0000;
  localparam soc_bus_pkg::addr_t GpioBaseAddr = 32'h0300_5000;
  localparam int unsigned PeriphWinBits = 12;

  typedef logic [PeriphWinBits-1:0] reg_ofs_t;

  // ------------------------------
  // Registers
  // ------------------------------
  localparam soc_bus_pkg::addr_t BootAddrDefault = SramBaseAddr;
  localparam reg_ofs_t CtrlBootAddrOfs  = 12'h000;
  localparam reg_ofs_t CtrlFetchEnOfs   = 12'h004;
  localparam reg_ofs_t GpioDirOfs       = 12'h000;
  localparam reg_ofs_t GpioOutOfs       = 12'h004;
  localparam reg_ofs_t GpioInOfs        = 12'h008;
  localparam reg_ofs_t GpioIrqEnOfs     = 12'h00C;
  localparam reg_ofs_t GpioIrqStatusOfs = 12'h010;
  localparam int unsigned GpioCount = 16;

  // Read data of the error target
  localparam soc_bus_pkg::data_t ErrRspData = 32'hBADC_AB1E;

endpackage

`default_nettype wire

/* hw/soc_addr_decode.sv */
// ----------------------------
// Address decoder, purely combinational.
// Unmapped addresses select TgtError and raise no target req.
// ----------------------------

`default_nettype none

module soc_addr_decode (
  input  logic                     req_i,
  input  logic                     we_i,
  input  soc_bus_pkg::addr_t       addr_i,
  input  soc_bus_pkg::data_t       wdata_i,
  input  soc_bus_pkg::strb_t       be_i,
  obi_bus_if.mgr                   sram_o,
  obi_bus_if.mgr                   ctrl_o,
  obi_bus_if.mgr                   gpio_o,
  output soc_map_pkg::soc_target_e sel_o,
  output logic                     acc_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic hit_sram;
  logic hit_ctrl;
  logic hit_gpio;

  // Window match on the upper address bits
  assign hit_sram = addr_i[AddrWidth-1:SramWinBits] == SramBaseAddr[AddrWidth-1:SramWinBits];
  assign hit_ctrl = addr_i[AddrWidth-1:PeriphWinBits] == CtrlBaseAddr[AddrWidth-1:PeriphWinBits];
  assign hit_gpio = addr_i[AddrWidth-1:PeriphWinBits] == GpioBaseAddr[AddrWidth-1:PeriphWinBits];

  always_comb begin
    sel_o = TgtError;
    if (hit_sram) begin
      sel_o = TgtSram;
    end else if (hit_ctrl) begin
      sel_o = TgtCtrl;
    end else if (hit_gpio) begin
      sel_o = TgtGpio;
    end
  end

  assign acc_o = req_i;

  // ------------------------------
  // Fan out with req only on the chosen target
  // ------------------------------
  assign sram_o.req   = req_i && (sel_o == TgtSram);
  assign sram_o.we    = we_i;
  assign sram_o.addr  = addr_i;
  assign sram_o.wdata = wdata_i;
  assign sram_o.be    = be_i;

  assign ctrl_o.req   = req_i && (sel_o == TgtCtrl);
  assign ctrl_o.we    = we_i;
  assign ctrl_o.addr  = addr_i;
  assign ctrl_o.wdata = wdata_i;
  assign ctrl_o.be    = be_i;

  assign gpio_o.req   = req_i && (sel_o == TgtGpio);
  assign gpio_o.we    = we_i;
  assign gpio_o.addr  = addr_i;
  assign gpio_o.wdata = wdata_i;
  assign gpio_o.be    = be_i;

endmodule

`default_nettype wire

/* hw/soc_lite_top.sv */
// ----------------------------
// soc_lite top level, one bus manager port.
// Grant is always given; the manager must accept a response
// exactly one cycle after each request.
// ----------------------------

`default_nettype none

module soc_lite_top (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  // Bus request
  input  logic                              req_i,
  input  logic                              we_i,
  input  soc_bus_pkg::addr_t                addr_i,
  input  soc_bus_pkg::data_t                wdata_i,
  input  soc_bus_pkg::strb_t                be_i,
  // Bus response
  output logic                              gnt_o,
  output logic                              rvalid_o,
  output soc_bus_pkg::data_t                rdata_o,
  output logic                              err_o,
  // SoC control
  input  logic                              fetch_en_i,
  output logic                              fetch_enable_o,
  output soc_bus_pkg::addr_t                boot_addr_o,
  // GPIO
  input  logic [soc_map_pkg::GpioCount-1:0] gpio_i,
  output logic [soc_map_pkg::GpioCount-1:0] gpio_o,
  output logic [soc_map_pkg::GpioCount-1:0] gpio_out_en_o,
  output logic                              gpio_irq_o
);
  import soc_map_pkg::*;

  soc_target_e sel;
  logic        acc;

  obi_bus_if sram_bus ();
  obi_bus_if ctrl_bus ();
  obi_bus_if gpio_bus ();

  assign gnt_o = req_i;

  // ------------------------------
  // Decode, targets, return path
  // ------------------------------
  soc_addr_decode i_addr_decode (
    .req_i, .we_i, .addr_i, .wdata_i, .be_i,
    .sram_o ( sram_bus ),
    .ctrl_o ( ctrl_bus ),
    .gpio_o ( gpio_bus ),
    .sel_o  ( sel      ),
    .acc_o  ( acc      )
  );

  sram_bank i_sram_bank (
    .clk_i, .arst_n_i,
    .bus ( sram_bus )
  );

  soc_ctrl_regs i_soc_ctrl (
    .clk_i, .arst_n_i,
    .bus ( ctrl_bus ),
    .fetch_en_i, .fetch_enable_o, .boot_addr_o
  );

  gpio_regs i_gpio (
    .clk_i, .arst_n_i,
    .bus   ( gpio_bus   ),
    .gpio_i, .gpio_o, .gpio_out_en_o,
    .irq_o ( gpio_irq_o )
  );

  soc_rsp_mux i_rsp_mux (
    .clk_i, .arst_n_i,
    .sel_i  ( sel      ),
    .acc_i  ( acc      ),
    .sram_i ( sram_bus ),
    .ctrl_i ( ctrl_bus ),
    .gpio_i ( gpio_bus ),
    .rvalid_o, .rdata_o, .err_o
  );

endmodule

`default_nettype wire

/* hw/soc_rsp_mux.sv */
// ----------------------------
// Response return path.
// Remembers which target took the request and returns that
// target's response one cycle later. Unmapped requests get
// ErrRspData with err set; nothing is written for them.
// ----------------------------

`default_nettype none

module soc_rsp_mux (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  soc_map_pkg::soc_target_e sel_i,
  input  logic                     acc_i,
  obi_bus_if.mon                   sram_i,
  obi_bus_if.mon                   ctrl_i,
  obi_bus_if.mon                   gpio_i,
  output logic                     rvalid_o,
  output soc_bus_pkg::data_t       rdata_o,
  output logic                     err_o
);
  import soc_map_pkg::*;

  soc_target_e sel_q;
  logic        acc_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q <= TgtSram;
      acc_q <= 1'b0;
    end else begin
      sel_q <= sel_i;
      acc_q <= acc_i;
    end
  end

  always_comb begin
    case (sel_q)
      TgtSram: begin
        rvalid_o = sram_i.rvalid;
        rdata_o  = sram_i.rdata;
        err_o    = sram_i.err;
      end
      TgtCtrl: begin
        rvalid_o = ctrl_i.rvalid;
        rdata_o  = ctrl_i.rdata;
        err_o    = ctrl_i.err;
      end
      TgtGpio: begin
        rvalid_o = gpio_i.rvalid;
        rdata_o  = gpio_i.rdata;
        err_o    = gpio_i.err;
      end
      // Error target has no state and is answered here
      default: begin
        rvalid_o = acc_q;
        rdata_o  = ErrRspData;
        err_o    = acc_q;
      end
    endcase
  end

endmodule

`default_nettype wire

/* mem/sram_bank.sv */
// ----------------------------
// Single-port word SRAM, read latency of one cycle.
// Word index is taken from the low address bits only, so the
// decoder must have checked the window already.
// Contents are undefined after power up.
// ----------------------------

`default_nettype none

module sram_bank (
  input  logic   clk_i,
  input  logic   arst_n_i,
  obi_bus_if.sbr bus
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  data_t                   mem_q [SramNumWords];
  logic [SramIdxWidth-1:0] word_idx;

  assign word_idx = bus.addr[SramIdxWidth+1:2];

  // Storage and read port
  always_ff @(posedge clk_i) begin
    if (bus.req && bus.we) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (bus.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
    if (bus.req && !bus.we) begin
      bus.rdata <= mem_q[word_idx];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= bus.req;
    end
  end

  assign bus.err = 1'b0;

endmodule

`default_nettype wire

/* periph/gpio_regs.sv */
// ----------------------------
// GPIO block with per-pin direction and rising edge interrupt.
// Inputs pass a two-flop synchronizer, so a pin edge sets its
// status bit on the third clock after the pin changes.
// Status bits are write-one-to-clear; a new edge wins over a clear.
// ----------------------------

`default_nettype none

module gpio_regs (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  obi_bus_if.sbr                            bus,
  input  logic [soc_map_pkg::GpioCount-1:0] gpio_i,
  output logic [soc_map_pkg::GpioCount-1:0] gpio_o,
  output logic [soc_map_pkg::GpioCount-1:0] gpio_out_en_o,
  output logic                              irq_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  typedef logic [GpioCount-1:0] pins_t;

  reg_ofs_t ofs;
  logic     wr_en;
  pins_t    wr_pins;
  data_t    rdata_d;
  pins_t    dir_q;
  pins_t    out_q;
  pins_t    irq_en_q;
  pins_t    status_q;
  pins_t    sync1_q;
  pins_t    sync2_q;
  pins_t    prev_q;
  pins_t    rise;
  pins_t    clr;

  assign ofs     = bus.addr[PeriphWinBits-1:0];
  assign wr_en   = bus.req && bus.we;
  assign wr_pins = bus.wdata[GpioCount-1:0];

  // Enabled rising edges of the synchronized pins
  assign rise = sync2_q & ~prev_q & irq_en_q;
  assign clr  = (wr_en && (ofs == GpioIrqStatusOfs)) ? wr_pins : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_q      <= '0;
      out_q      <= '0;
      irq_en_q   <= '0;
      status_q   <= '0;
      sync1_q    <= '0;
      sync2_q    <= '0;
      prev_q     <= '0;
      bus.rvalid <= 1'b0;
    end else begin
      sync1_q    <= gpio_i;
      sync2_q    <= sync1_q;
      prev_q     <= sync2_q;
      status_q   <= (status_q & ~clr) | rise;
      bus.rvalid <= bus.req;
      if (wr_en && (ofs == GpioDirOfs))   dir_q    <= wr_pins;
      if (wr_en && (ofs == GpioOutOfs))   out_q    <= wr_pins;
      if (wr_en && (ofs == GpioIrqEnOfs)) irq_en_q <= wr_pins;
    end
  end

  // ------------------------------
  // Read path
  // ------------------------------
  always_comb begin
    rdata_d = '0;
    case (ofs)
      GpioDirOfs:       rdata_d[GpioCount-1:0] = dir_q;
      GpioOutOfs:       rdata_d[GpioCount-1:0] = out_q;
      GpioInOfs:        rdata_d[GpioCount-1:0] = sync2_q;
      GpioIrqEnOfs:     rdata_d[GpioCount-1:0] = irq_en_q;
      GpioIrqStatusOfs: rdata_d[GpioCount-1:0] = status_q;
      default:          rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus.req && !bus.we) begin
      bus.rdata <= rdata_d;
    end
  end

  assign bus.err       = 1'b0;
  assign gpio_o        = out_q;
  assign gpio_out_en_o = dir_q;
  assign irq_o         = |status_q;

endmodule

`default_nettype wire

/* periph/soc_ctrl_regs.sv */
// ----------------------------
// SoC control registers: boot address and fetch enable.
// Writes take the full word, byte enables are ignored.
// Unknown offsets read zero and never report an error.
// ----------------------------

`default_nettype none

module soc_ctrl_regs (
  input  logic               clk_i,
  input  logic               arst_n_i,
  obi_bus_if.sbr             bus,
  input  logic               fetch_en_i,
  output logic               fetch_enable_o,
  output soc_bus_pkg::addr_t boot_addr_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  reg_ofs_t ofs;
  logic     wr_en;
  data_t    rdata_d;
  addr_t    boot_addr_q;
  logic     fetch_en_q;

  assign ofs   = bus.addr[PeriphWinBits-1:0];
  assign wr_en = bus.req && bus.we;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      boot_addr_q <= BootAddrDefault;
      fetch_en_q  <= 1'b0;
      bus.rvalid  <= 1'b0;
    end else begin
      bus.rvalid <= bus.req;
      if (wr_en && (ofs == CtrlBootAddrOfs)) begin
        boot_addr_q <= bus.wdata;
      end
      if (wr_en && (ofs == CtrlFetchEnOfs)) begin
        fetch_en_q <= bus.wdata[0];
      end
    end
  end

  // Read mux
  always_comb begin
    rdata_d = '0;
    case (ofs)
      CtrlBootAddrOfs: rdata_d = boot_addr_q;
      CtrlFetchEnOfs:  rdata_d[0] = fetch_en_q;
      default:         rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus.req && !bus.we) begin
      bus.rdata <= rdata_d;
    end
  end

  assign bus.err = 1'b0;

  // Core may only fetch when both the pin and the register agree
  assign fetch_enable_o = fetch_en_q & fetch_en_i;
  assign boot_addr_o    = boot_addr_q;

endmodule

`default_nettype wire

/* soc_lite.f */
common/soc_bus_pkg.sv
common/soc_map_pkg.sv
common/obi_bus_if.sv
hw/soc_addr_decode.sv
mem/sram_bank.sv
periph/soc_ctrl_regs.sv
periph/gpio_regs.sv
hw/soc_rsp_mux.sv
hw/soc_lite_top.sv
test/tb_soc_lite.sv

/* test/tb_soc_lite.sv */
// ----------------------------
// Self-checking testbench for soc_lite_top.
// Requests go out on the falling edge; each response is checked
// on the next falling edge, while the next request is driven.
// Only the SRAM words that the tests write are modelled.
// ----------------------------

`default_nettype none

module tb_soc_lite;

  localparam logic [31:0] SramBase    = 32'h1000_0000;
  localparam logic [31:0] CtrlBase    = 32'h0300_0000;
  localparam logic [31:0] GpioBase    = 32'h0300_5000;
  localparam logic [31:0] ErrData     = 32'hBADC_AB1E;
  localparam logic [31:0] BootOfs     = 32'h000;
  localparam logic [31:0] FetchEnOfs  = 32'h004;
  localparam logic [31:0] DirOfs      = 32'h000;
  localparam logic [31:0] OutOfs      = 32'h004;
  localparam logic [31:0] InOfs       = 32'h008;
  localparam logic [31:0] IrqEnOfs    = 32'h00C;
  localparam logic [31:0] IrqStatOfs  = 32'h010;
  localparam int          TestWords   = 16;
  // About twenty times the length of all tests
  localparam int          TimeoutCycles = 2000;

  logic        clk_i;
  logic        arst_n_i;
  logic        req_i;
  logic        we_i;
  logic [31:0] addr_i;
  logic [31:0] wdata_i;
  logic [3:0]  be_i;
  logic        gnt_o;
  logic        rvalid_o;
  logic [31:0] rdata_o;
  logic        err_o;
  logic        fetch_en_i;
  logic        fetch_enable_o;
  logic [31:0] boot_addr_o;
  logic [15:0] gpio_i;
  logic [15:0] gpio_o;
  logic [15:0] gpio_out_en_o;
  logic        gpio_irq_o;

  // Expected response of the request issued in the previous cycle
  logic        pend_valid;
  logic        pend_chk;
  logic [31:0] pend_data;
  logic        pend_err;
  logic [31:0] pend_addr;

  logic [31:0] model [TestWords];
  logic [31:0] lfsr_state;
  string       test_name;
  int          error_count;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  int          cycle_count;

  soc_lite_top soc_lite_top_i (
    .clk_i, .arst_n_i,
    .req_i, .we_i, .addr_i, .wdata_i, .be_i,
    .gnt_o, .rvalid_o, .rdata_o, .err_o,
    .fetch_en_i, .fetch_enable_o, .boot_addr_o,
    .gpio_i, .gpio_o, .gpio_out_en_o, .gpio_irq_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("Regression failed");
    $finish;
  end

  // ------------------------------
  // Random numbers
  // ------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // ------------------------------
  // Reporting
  // ------------------------------
  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("ERR %s %s: expected %08h, actual %08h", test_name, what, exp, act);
    error_count++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s: %s", test_name, msg);
    error_count++;
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = error_count;
  endtask

  // ------------------------------
  // Bus tasks
  // ------------------------------
  task automatic check_rsp();
    assert (gnt_o === req_i) else report_mismatch("gnt_o", req_i, gnt_o);
    if (pend_valid) begin
      assert (rvalid_o === 1'b1) else report_mismatch("rvalid_o", 1, rvalid_o);
      assert (err_o === pend_err)
        else report_mismatch($sformatf("err_o @%08h", pend_addr), pend_err, err_o);
      if (pend_chk) begin
        assert (rdata_o === pend_data)
          else report_mismatch($sformatf("rdata_o @%08h", pend_addr), pend_data, rdata_o);
      end
    end else begin
      assert (rvalid_o === 1'b0) else report_mismatch("idle rvalid_o", 0, rvalid_o);
    end
  endtask

  task automatic issue(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                       input logic [3:0] be, input logic chk, input logic [31:0] exp,
                       input logic exp_err);
    @(negedge clk_i);
    check_rsp();
    req_i      = 1'b1;
    we_i       = we;
    addr_i     = addr;
    wdata_i    = wdata;
    be_i       = be;
    pend_valid = 1'b1;
    pend_chk   = chk;
    pend_data  = exp;
    pend_err   = exp_err;
    pend_addr  = addr;
  endtask

  task automatic idle();
    @(negedge clk_i);
    check_rsp();
    req_i      = 1'b0;
    we_i       = 1'b0;
    pend_valid = 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    issue(1'b1, addr, data, be, 1'b0, '0, 1'b0);
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp);
    issue(1'b0, addr, '0, 4'hF, 1'b1, exp, 1'b0);
  endtask

  // Unmapped access, always answered with the error word
  task automatic bus_unmapped(input logic we, input logic [31:0] addr);
    issue(we, addr, 32'h1234_5678, 4'hF, 1'b1, ErrData, 1'b1);
  endtask

  task automatic sram_write(input int idx, input logic [31:0] data, input logic [3:0] be);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) model[idx][8*b +: 8] = data[8*b +: 8];
    end
    bus_write(SramBase + 32'(4 * idx), data, be);
  endtask

  // Drains the last response and prints one line per test
  task automatic end_test();
    idle();
    tests_run++;
    if (error_count != test_errors) tests_failed++;
    $display("%s %s (%0d errors)", test_name,
             (error_count == test_errors) ? "PASS" : "FAIL", error_count - test_errors);
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic test_reset();
    begin_test("reset");
    // Pin high so only the cleared register keeps fetch_enable_o low
    fetch_en_i = 1'b1;
    idle();
    assert (fetch_enable_o === 1'b0) else report_mismatch("fetch_enable_o", 0, fetch_enable_o);
    assert (gpio_out_en_o === '0) else report_mismatch("gpio_out_en_o", 0, gpio_out_en_o);
    assert (gpio_o === '0) else report_mismatch("gpio_o", 0, gpio_o);
    assert (gpio_irq_o === 1'b0) else report_mismatch("gpio_irq_o", 0, gpio_irq_o);
    assert (boot_addr_o === SramBase) else report_mismatch("boot_addr_o", SramBase, boot_addr_o);
    bus_read(CtrlBase + BootOfs, SramBase);
    end_test();
  endtask

  task automatic test_sram();
    logic [31:0] data;
    logic [3:0]  be;
    begin_test("sram");
    // Full words first so every later read is defined
    for (int i = 0; i < TestWords; i++) begin
      data = rand_bits(32);
      sram_write(i, data, 4'hF);
    end
    for (int i = 0; i < TestWords; i++) begin
      data = rand_bits(32);
      be   = 4'(rand_bits(4));
      sram_write(i, data, be);
    end
    for (int i = 0; i < TestWords; i++) begin
      bus_read(SramBase + 32'(4 * i), model[i]);
    end
    end_test();
  endtask

  task automatic test_error();
    begin_test("error");
    bus_unmapped(1'b0, 32'h0000_0000);
    // Aliases word 0 if the SRAM window is decoded too wide
    bus_unmapped(1'b1, 32'h1000_0800);
    bus_unmapped(1'b0, 32'h0300_1000);
    bus_unmapped(1'b1, 32'h2000_0000);
    bus_read(SramBase, model[0]);
    end_test();
  endtask

  task automatic test_ctrl();
    logic [31:0] boot;
    begin_test("ctrl");
    fetch_en_i = 1'b0;
    bus_write(CtrlBase + FetchEnOfs, 32'h1, 4'hF);
    idle();
    assert (fetch_enable_o === 1'b0) else report_mismatch("fetch_enable_o", 0, fetch_enable_o);
    fetch_en_i = 1'b1;
    idle();
    assert (fetch_enable_o === 1'b1) else report_mismatch("fetch_enable_o", 1, fetch_enable_o);
    bus_read(CtrlBase + FetchEnOfs, 32'h1);
    boot = rand_bits(32) & 32'hFFFF_FFFC;
    // Byte enables are ignored and the whole word is taken
    bus_write(CtrlBase + BootOfs, boot, 4'h1);
    idle();
    assert (boot_addr_o === boot) else report_mismatch("boot_addr_o", boot, boot_addr_o);
    bus_read(CtrlBase + BootOfs, boot);
    end_test();
  endtask

  task automatic test_gpio();
    logic [15:0] dir;
    logic [15:0] out;
    logic [15:0] pins;
    logic        seen;
    begin_test("gpio");
    dir = 16'(rand_bits(16));
    out = 16'(rand_bits(16));
    bus_write(GpioBase + DirOfs, {16'h0, dir}, 4'hF);
    bus_write(GpioBase + OutOfs, {16'h0, out}, 4'hF);
    idle();
    assert (gpio_out_en_o === dir) else report_mismatch("gpio_out_en_o", dir, gpio_out_en_o);
    assert (gpio_o === out) else report_mismatch("gpio_o", out, gpio_o);
    pins   = 16'(rand_bits(16));
    gpio_i = pins;
    repeat (4) idle();
    bus_read(GpioBase + InOfs, {16'h0, pins});
    gpio_i = '0;
    // Edge interrupt on pin 3 only
    bus_write(GpioBase + IrqEnOfs, 32'h0008, 4'hF);
    repeat (4) idle();
    gpio_i = 16'h0020;
    repeat (6) idle();
    assert (gpio_irq_o === 1'b0)
      else report_failure("gpio_irq_o rose after an edge on a disabled pin");
    gpio_i = 16'h0028;
    seen   = 1'b0;
    for (int k = 0; k < 4 && !seen; k++) begin
      idle();
      seen = gpio_irq_o;
    end
    assert (seen === 1'b1)
      else report_failure("gpio_irq_o did not rise within 4 cycles of an enabled pin edge");
    bus_read(GpioBase + IrqStatOfs, 32'h0008);
    bus_write(GpioBase + IrqStatOfs, 32'h0008, 4'hF);
    idle();
    assert (gpio_irq_o === 1'b0) else report_mismatch("gpio_irq_o after clear", 0, gpio_irq_o);
    bus_read(GpioBase + IrqStatOfs, 32'h0000);
    end_test();
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    arst_n_i     = 1'b0;
    req_i        = 1'b0;
    we_i         = 1'b0;
    addr_i       = '0;
    wdata_i      = '0;
    be_i         = '0;
    fetch_en_i   = 1'b0;
    gpio_i       = '0;
    pend_valid   = 1'b0;
    pend_chk     = 1'b0;
    pend_data    = '0;
    pend_err     = 1'b0;
    pend_addr    = '0;
    lfsr_state   = 32'h500e_cd17;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (2) @(negedge clk_i);
    arst_n_i = 1'b1;

    test_reset();
    test_sram();
    test_error();
    test_ctrl();
    test_gpio();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
